//--- build.f
source/meshFieldPkg.sv
source/neighborTablePkg.sv
source/packetLatch.sv
source/neighborTable.sv
source/nextHopSelect.sv
source/qtuFmbTop.sv
test/qtuFmbTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module qtuFmbTb -f build.f -o simv
./obj_dir/simv | tee sim.log

if grep -q "Checks failed" sim.log; then
    exit 1
fi

//--- source/meshFieldPkg.sv
package meshFieldPkg;

    // every packet field is one 16-bit word
    localparam int wordWidth = 16;

    // sender or cluster head address
    typedef logic [wordWidth-1:0] nodeIdT;

    // distance from the cluster head, in hops
    typedef logic [wordWidth-1:0] hopCountT;

    // link quality, compared unsigned
    typedef logic [wordWidth-1:0] qValueT;

    // remaining battery of the sender
    typedef logic [wordWidth-1:0] energyT;

    // all ones marks "no node picked yet"
    localparam nodeIdT noNode = '1;

    // all ones marks an unknown hop count
    localparam hopCountT noHops = '1;

endpackage

//--- source/neighborTable.sv
`timescale 1ns/1ps

module neighborTable
    import meshFieldPkg::*, neighborTablePkg::*;
#(
    parameter int tableDepth = defaultTableDepth
)(
    input  logic       clk,
    input  logic       nrst,
    input  logic       hbReset,
    input  logic       latchValid,
    input  logic       sameCluster,
    input  logic       bestQualified,
    input  nodeIdT     srcId,
    input  hopCountT   srcHops,
    input  qValueT     srcQValue,
    input  energyT     srcEnergy,
    input  hopCountT   srcHopsFromCh,
    output nodeIdT     nodeId,
    output hopCountT   nodeHops,
    output energyT     nodeEnergy,
    output qValueT     nodeQValue,
    output tableIndexT neighborIndex,
    output logic       done,
    output logic       recValid,
    output nodeIdT     recId,
    output qValueT     recQValue,
    output hopCountT   recHopsFromCh,
    output logic       recQualified
);

    // per entry valid flag and sender id
    logic       entryValid [tableDepth];
    nodeIdT     entryId    [tableDepth];
    tableCountT neighborCount;

    // lookup results
    logic [tableDepth-1:0] hitVec;
    tableIndexT            hitIndex;
    tableIndexT            freeIndex;
    logic                  hit;
    logic                  accept;
    logic                  allocate;
    logic                  writeRec;

    // parallel compare against every live entry
    always_comb begin
        for (int i = 0; i < tableDepth; i++) begin
            hitVec[i] = entryValid[i] && (entryId[i] == srcId);
        end
    end

    // one-hot to index, OR of the set positions
    always_comb begin
        hitIndex = '0;
        for (int i = 0; i < tableDepth; i++) begin
            if (hitVec[i]) begin
                hitIndex = hitIndex | tableIndexT'(i);
            end
        end
    end

    assign hit       = |hitVec;
    // next free slot is the count itself, entries fill in order
    assign freeIndex = neighborCount[$bits(tableIndexT)-1:0];
    assign accept    = latchValid && sameCluster && !hbReset;
    // full table drops a new sender
    assign allocate  = accept && !hit && (neighborCount < tableCountT'(tableDepth));
    assign writeRec  = (accept && hit) || allocate;

    // valid bits and count
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            neighborCount <= '0;
            for (int i = 0; i < tableDepth; i++) begin
                entryValid[i] <= 1'b0;
            end
        end else if (hbReset) begin
            neighborCount <= '0;
            for (int i = 0; i < tableDepth; i++) begin
                entryValid[i] <= 1'b0;
            end
        end else if (allocate) begin
            entryValid[freeIndex] <= 1'b1;
            neighborCount         <= neighborCount + 1'b1;
        end
    end

    // id storage, guarded by the valid bits
    always_ff @(posedge clk) begin
        if (allocate) begin
            entryId[freeIndex] <= srcId;
        end
    end

    // record for the neighbor table write, plus done
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            done          <= 1'b0;
            nodeId        <= '0;
            nodeHops      <= noHops;
            nodeEnergy    <= '0;
            nodeQValue    <= '0;
            neighborIndex <= '0;
        end else begin
            done <= writeRec;
            if (writeRec) begin
                nodeId        <= srcId;
                nodeHops      <= srcHops;
                nodeEnergy    <= srcEnergy;
                nodeQValue    <= srcQValue;
                neighborIndex <= hit ? hitIndex : freeIndex;
            end
        end
    end

    // every packet goes on to stage 3, cluster match or not
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            recValid     <= 1'b0;
            recQualified <= 1'b0;
        end else begin
            recValid     <= latchValid && !hbReset;
            recQualified <= bestQualified;
        end
    end

    // forwarded payload
    always_ff @(posedge clk) begin
        if (latchValid) begin
            recId         <= srcId;
            recQValue     <= srcQValue;
            recHopsFromCh <= srcHopsFromCh;
        end
    end

    // allocation only on a miss, so an id lives in at most one slot
    assert property (@(posedge clk) disable iff (!nrst) $onehot0(hitVec));

    assert property (@(posedge clk) disable iff (!nrst)
        neighborCount <= tableCountT'(tableDepth));

endmodule

//--- source/neighborTablePkg.sv
package neighborTablePkg;

    // hard ceiling on entries, fixes the index width
    localparam int maxTableDepth = 32;

    // depth used unless the top level picks a smaller one
    localparam int defaultTableDepth = 32;

    // slot number inside the neighbor table
    typedef logic [$clog2(maxTableDepth)-1:0] tableIndexT;

    // neighbor count, one bit wider so a full table fits
    typedef logic [$clog2(maxTableDepth):0] tableCountT;

endpackage

//--- source/nextHopSelect.sv
`timescale 1ns/1ps

module nextHopSelect
    import meshFieldPkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     hbReset,
    input  logic     recValid,
    input  nodeIdT   recId,
    input  qValueT   recQValue,
    input  hopCountT recHopsFromCh,
    input  logic     recQualified,
    input  nodeIdT   chosenCh,
    input  hopCountT hopsFromCh,
    output nodeIdT   chosenHop
);

    // best Q-value among candidates one hop closer
    qValueT   maxQValue;
    hopCountT hopsNeeded;
    logic     consider;
    logic     oneHopFromCh;
    logic     closerHop;
    logic     betterQ;

    // candidate must sit exactly one hop nearer the head
    assign hopsNeeded   = hopsFromCh - hopCountT'(1);
    assign consider     = recValid && recQualified && !hbReset;
    assign oneHopFromCh = (hopsFromCh == hopCountT'(1));
    assign closerHop    = (recHopsFromCh == hopsNeeded);

    // higher Q wins, lower id breaks a tie
    assign betterQ = (recQValue > maxQValue) ||
                     ((recQValue == maxQValue) && (recId < chosenHop));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            chosenHop <= noNode;
            maxQValue <= '0;
        end else if (hbReset) begin
            chosenHop <= noNode;
            maxQValue <= '0;
        end else if (consider) begin
            if (oneHopFromCh) begin
                // head is a direct neighbor, always send there
                chosenHop <= chosenCh;
            end else if (closerHop && betterQ) begin
                chosenHop <= recId;
                maxQValue <= recQValue;
            end
        end
    end

endmodule

//--- source/packetLatch.sv
`timescale 1ns/1ps

module packetLatch
    import meshFieldPkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     en,
    input  logic     hbReset,
    input  logic     iAmDestination,
    input  nodeIdT   fSourceId,
    input  hopCountT fSourceHops,
    input  qValueT   fQValue,
    input  energyT   fEnergyLeft,
    input  hopCountT fHopsFromCh,
    input  nodeIdT   fChosenCh,
    input  nodeIdT   chosenCh,
    output logic     latchValid,
    output logic     sameCluster,
    output logic     bestQualified,
    output nodeIdT   srcId,
    output hopCountT srcHops,
    output qValueT   srcQValue,
    output energyT   srcEnergy,
    output hopCountT srcHopsFromCh
);

    // heartbeat wins over a packet in the same cycle
    logic capture;

    assign capture = en && !hbReset;

    // control bits, cleared by nrst
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            latchValid    <= 1'b0;
            sameCluster   <= 1'b0;
            bestQualified <= 1'b0;
        end else begin
            latchValid <= capture;
            if (capture) begin
                // cluster membership decided here only
                sameCluster   <= (fChosenCh == chosenCh);
                bestQualified <= iAmDestination;
            end
        end
    end

    // packet fields, only meaningful with latchValid
    always_ff @(posedge clk) begin
        if (capture) begin
            srcId         <= fSourceId;
            srcHops       <= fSourceHops;
            srcQValue     <= fQValue;
            srcEnergy     <= fEnergyLeft;
            srcHopsFromCh <= fHopsFromCh;
        end
    end

endmodule

//--- source/qtuFmbTop.sv
`timescale 1ns/1ps

module qtuFmbTop
    import meshFieldPkg::*, neighborTablePkg::*;
#(
    parameter int tableDepth = defaultTableDepth
)(
    input  logic       clk,
    input  logic       nrst,
    input  logic       en,
    input  logic       iAmDestination,
    input  logic       hbReset,
    input  nodeIdT     fSourceId,
    input  hopCountT   fSourceHops,
    input  qValueT     fQValue,
    input  energyT     fEnergyLeft,
    input  hopCountT   fHopsFromCh,
    input  nodeIdT     fChosenCh,
    input  nodeIdT     chosenCh,
    input  hopCountT   hopsFromCh,
    output nodeIdT     nodeId,
    output hopCountT   nodeHops,
    output energyT     nodeEnergy,
    output qValueT     nodeQValue,
    output tableIndexT neighborIndex,
    output nodeIdT     chosenHop,
    output logic       done
);

    // stage 1 to stage 2
    logic     latchValid;
    logic     sameCluster;
    logic     bestQualified;
    nodeIdT   srcId;
    hopCountT srcHops;
    qValueT   srcQValue;
    energyT   srcEnergy;
    hopCountT srcHopsFromCh;

    // stage 2 to stage 3
    logic     recValid;
    nodeIdT   recId;
    qValueT   recQValue;
    hopCountT recHopsFromCh;
    logic     recQualified;

    packetLatch uLatch (
        .clk, .nrst, .en, .hbReset, .iAmDestination,
        .fSourceId, .fSourceHops, .fQValue, .fEnergyLeft, .fHopsFromCh, .fChosenCh,
        .chosenCh,
        .latchValid, .sameCluster, .bestQualified,
        .srcId, .srcHops, .srcQValue, .srcEnergy, .srcHopsFromCh
    );

    neighborTable #(.tableDepth(tableDepth)) uTable (
        .clk, .nrst, .hbReset,
        .latchValid, .sameCluster, .bestQualified,
        .srcId, .srcHops, .srcQValue, .srcEnergy, .srcHopsFromCh,
        .nodeId, .nodeHops, .nodeEnergy, .nodeQValue, .neighborIndex, .done,
        .recValid, .recId, .recQValue, .recHopsFromCh, .recQualified
    );

    nextHopSelect uSelect (
        .clk, .nrst, .hbReset,
        .recValid, .recId, .recQValue, .recHopsFromCh, .recQualified,
        .chosenCh, .hopsFromCh,
        .chosenHop
    );

endmodule

//--- test/qtuFmbTb.sv
`timescale 1ns/1ps

module qtuFmbTb
    import meshFieldPkg::*, neighborTablePkg::*;
();

    localparam int depth       = defaultTableDepth;
    localparam int doneTimeout = 4;

    logic       clk = 1'b0;
    logic       nrst, en, iAmDestination, hbReset, done;
    nodeIdT     fSourceId, fChosenCh, chosenCh, nodeId, chosenHop;
    hopCountT   fSourceHops, fHopsFromCh, hopsFromCh, nodeHops;
    qValueT     fQValue, nodeQValue;
    energyT     fEnergyLeft, nodeEnergy;
    tableIndexT neighborIndex;

    int          errorCount   = 0;
    int          timeoutCount = 0;
    logic [15:0] lfsrState    = 16'd56;
    // reference model: ids in slot order, best candidate so far
    nodeIdT      knownIds[$];
    nodeIdT      bestId;
    qValueT      bestQ;

    always #2 clk = ~clk;

    qtuFmbTop #(.tableDepth(depth)) dut (.*);

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic takeBits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[14:0], lfsrState[0]};
        end
    endtask

    task automatic valueError(input string name, input logic [15:0] exp, input logic [15:0] act);
        errorCount++;
        $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
    endtask

    task automatic checkNodeId(input string name, input nodeIdT exp, input nodeIdT act);
        if (act !== exp) begin
            valueError(name, exp, act);
        end
    endtask

    task automatic checkIndex(input string name, input tableIndexT exp, input tableIndexT act);
        if (act !== exp) begin
            valueError(name, 16'(exp), 16'(act));
        end
    endtask

    task automatic checkQValue(input string name, input qValueT exp, input qValueT act);
        if (act !== exp) begin
            valueError(name, exp, act);
        end
    endtask

    task automatic checkHops(input string name, input hopCountT exp, input hopCountT act);
        if (act !== exp) begin
            valueError(name, exp, act);
        end
    endtask

    task automatic checkEnergy(input string name, input energyT exp, input energyT act);
        if (act !== exp) begin
            valueError(name, exp, act);
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            valueError(name, 16'(exp), 16'(act));
        end
    endtask

    // called just after a falling edge, holds en for that cycle
    task automatic drivePacket(input nodeIdT id, input hopCountT srcHops,
                               input hopCountT chHops, input qValueT q, input energyT e,
                               input nodeIdT ch, input logic dest);
        fSourceId      = id;
        fSourceHops    = srcHops;
        fHopsFromCh    = chHops;
        fQValue        = q;
        fEnergyLeft    = e;
        fChosenCh      = ch;
        iAmDestination = dest;
        en             = 1'b1;
        @(negedge clk);
    endtask

    task automatic sendPacket(input nodeIdT id, input hopCountT srcHops,
                              input hopCountT chHops, input qValueT q, input energyT e,
                              input nodeIdT ch, input logic dest);
        drivePacket(id, srcHops, chHops, q, e, ch, dest);
        en = 1'b0;
    endtask

    // done may already be up on entry, bounded by the pipeline latency
    task automatic waitDone(output logic seen);
        seen = done;
        for (int i = 0; i < doneTimeout && !seen; i++) begin
            @(negedge clk);
            seen = done;
        end
    endtask

    // top bit set gives ids that never enter the model
    task automatic freshId(input logic top, output nodeIdT id);
        logic [15:0] r;
        takeBits(10, r);
        id = {top, r[9:0], 5'(knownIds.size())};
    endtask

    // expected slot follows arrival order, full table drops new ids
    task automatic sendTracked(input nodeIdT id, input qValueT q, input energyT e,
                               input hopCountT hops);
        int       idx;
        logic     seen;
        hopCountT srcHops;
        idx = -1;
        foreach (knownIds[i]) begin
            if (knownIds[i] == id) begin
                idx = i;
            end
        end
        if (idx < 0 && knownIds.size() < depth) begin
            idx = knownIds.size();
            knownIds.push_back(id);
        end
        // path hop count kept apart from the head distance
        takeBits(16, srcHops);
        sendPacket(id, srcHops, hops, q, e, chosenCh, 1'b0);
        waitDone(seen);
        if (idx < 0 && seen) begin
            errorCount++;
            $display("done pulsed at %0t for id %h, which should be dropped", $time, id);
        end else if (idx >= 0 && !seen) begin
            timeoutCount++;
            $display("no done pulse within %0d cycles for id %h", doneTimeout, id);
        end else if (idx >= 0) begin
            checkNodeId("nodeId", id, nodeId);
            checkHops("nodeHops", srcHops, nodeHops);
            checkQValue("nodeQValue", q, nodeQValue);
            checkEnergy("nodeEnergy", e, nodeEnergy);
            checkIndex("neighborIndex", tableIndexT'(idx), neighborIndex);
        end
    endtask

    task automatic testAllocation();
        nodeIdT      id;
        logic [15:0] q, e;
        for (int i = 0; i < 4; i++) begin
            freshId(1'b0, id);
            takeBits(16, q);
            takeBits(16, e);
            sendTracked(id, q, e, 16'd2);
        end
    endtask

    task automatic testUpdate();
        nodeIdT      id;
        logic [15:0] q, e;
        logic        seen;
        int          idx;
        takeBits(16, q);
        takeBits(16, e);
        sendTracked(knownIds[1], q, e, 16'd2);
        freshId(1'b0, id);
        sendTracked(id, q, e, 16'd2);
        // new id then the same id back to back, second must hit
        freshId(1'b0, id);
        idx = knownIds.size();
        knownIds.push_back(id);
        drivePacket(id, 16'd4, 16'd2, 16'h0011, e, chosenCh, 1'b0);
        drivePacket(id, 16'd4, 16'd2, 16'h0022, e, chosenCh, 1'b0);
        en = 1'b0;
        waitDone(seen);
        if (!seen) begin
            timeoutCount++;
            $display("no done pulse within %0d cycles for the burst", doneTimeout);
        end else begin
            checkIndex("neighborIndex", tableIndexT'(idx), neighborIndex);
            checkQValue("nodeQValue", 16'h0011, nodeQValue);
            @(negedge clk);
            checkBit("done", 1'b1, done);
            checkIndex("neighborIndex", tableIndexT'(idx), neighborIndex);
            checkQValue("nodeQValue", 16'h0022, nodeQValue);
        end
    endtask

    task automatic testFilterFull();
        nodeIdT id;
        logic   seen;
        freshId(1'b1, id);
        sendPacket(id, 16'd2, 16'd2, 16'h0033, 16'h0044, chosenCh ^ 16'h0001, 1'b0);
        waitDone(seen);
        if (seen) begin
            errorCount++;
            $display("done pulsed at %0t for a foreign cluster packet", $time);
        end
        while (knownIds.size() < depth) begin
            freshId(1'b0, id);
            sendTracked(id, 16'h0055, 16'h0066, 16'd2);
        end
        freshId(1'b1, id);
        sendTracked(id, 16'h0077, 16'h0088, 16'd2);
    endtask

    // model of the best tracker, only hop 2 counts when three hops out
    task automatic sendCandidate(input nodeIdT id, input qValueT q, input hopCountT hops);
        // path hop count swaps 1 and 2 so a mixed-up field picks the wrong senders
        sendPacket(id, hops ^ 16'd3, hops, q, 16'h0100, chosenCh, 1'b1);
        if (hops == 16'd2 && (q > bestQ || (q == bestQ && id < bestId))) begin
            bestId = id;
            bestQ  = q;
        end
    endtask

    task automatic testBestHop();
        logic [15:0] id, q;
        hopsFromCh = 16'd3;
        bestId     = noNode;
        bestQ      = '0;
        for (int i = 0; i < 8; i++) begin
            takeBits(16, id);
            takeBits(16, q);
            sendCandidate(id, q, (i % 2 == 0) ? 16'd2 : 16'd1);
        end
        // tie on Q, lower id takes over
        sendCandidate(bestId - 16'd1, bestQ, 16'd2);
        sendCandidate(bestId + 16'd5, bestQ, 16'd2);
        repeat (3) @(negedge clk);
        checkNodeId("chosenHop", bestId, chosenHop);
        hopsFromCh = 16'd1;
        sendCandidate(16'h0123, 16'h0001, 16'd0);
        repeat (3) @(negedge clk);
        checkNodeId("chosenHop", chosenCh, chosenHop);
    endtask

    task automatic testHeartbeat();
        nodeIdT id;
        hbReset = 1'b1;
        @(negedge clk);
        hbReset = 1'b0;
        checkNodeId("chosenHop", noNode, chosenHop);
        knownIds.delete();
        freshId(1'b0, id);
        sendTracked(id, 16'h0099, 16'h00AA, 16'd2);
    endtask

    initial begin
        en             = 1'b0;
        iAmDestination = 1'b0;
        hbReset        = 1'b0;
        fSourceId      = '0;
        fSourceHops    = '0;
        fQValue        = '0;
        fEnergyLeft    = '0;
        fHopsFromCh    = '0;
        fChosenCh      = '0;
        chosenCh       = 16'h00C1;
        hopsFromCh     = 16'd3;
        nrst           = 1'b0;
        repeat (10) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);
        testAllocation();
        testUpdate();
        testFilterFull();
        testBestHop();
        testHeartbeat();
        $display("errors: %0d wrong values, %0d missing done pulses", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
